/* Makefile */
# Verilator build and run for the Huffman coder

VERILATOR ?= verilator
TOP       ?= tb_huffman
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= All checks passed

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$($(SIM_BIN) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* code_builder.sv */
`timescale 1ns/1ns

module code_builder import huffman_pkg::*; (
	input  logic         clk,
	input  logic         reset,
	input  phase_t       phase,
	input  merge_event_t merge,
	output code_bank_t   code,
	output logic         code_valid
);

	logic [NUM_SYMBOLS-1:0][CODE_W-1:0] bit_pos;        // one-hot slot for next bit

	// mask is right aligned ones, so the next bit sits at its lowest zero
	always_comb begin
		for (int k = 0; k < NUM_SYMBOLS; k++) begin
			bit_pos[k] = ~code[k].mask & (code[k].mask + 1'b1);
		end
	end

	// ==================================================
	// code bit accumulation
	// ==================================================
	always_ff @(posedge clk) begin
		if (reset) begin
			code <= '0;
		end else if (merge.strobe) begin
			for (int k = 0; k < NUM_SYMBOLS; k++) begin
				if (merge.one_mask[k]) begin
					code[k].code <= code[k].code | bit_pos[k];
					code[k].mask <= code[k].mask | bit_pos[k];
				end else if (merge.zero_mask[k]) begin
					code[k].mask <= code[k].mask | bit_pos[k];   // code bit stays 0
				end
			end
		end
	end

	// a merge cycle without strobe is the last one before done
	always_ff @(posedge clk) begin
		if (reset) begin
			code_valid <= 1'b0;
		end else if (phase == phase_merge && !merge.strobe) begin
			code_valid <= 1'b1;
		end
	end

endmodule

/* files.f */
huffman_pkg.sv
symbol_histogram.sv
huffman_sequencer.sv
merge_sorter.sv
code_builder.sv
huffman.sv
huffman_chk.sv
tb_huffman.sv

/* huffman.sv */
`timescale 1ns/1ns

module huffman import huffman_pkg::*; (
	input  logic              clk,
	input  logic              reset,
	input  logic              gray_valid,
	input  logic [DATA_W-1:0] gray_data,
	output logic              cnt_valid,
	output count_bank_t       counts,
	output logic              code_valid,
	output code_bank_t        code
);

	phase_t       phase;
	logic         sort_done;
	merge_event_t merge;

	// ==================================================
	// count, merge, build chain
	// ==================================================
	huffman_sequencer huffman_sequencer_inst (
		.clk        (clk),
		.reset      (reset),
		.gray_valid (gray_valid),
		.sort_done  (sort_done),
		.phase      (phase),
		.cnt_valid  (cnt_valid)
	);

	symbol_histogram symbol_histogram_inst (
		.clk        (clk),
		.reset      (reset),
		.phase      (phase),
		.gray_valid (gray_valid),
		.gray_data  (gray_data),
		.counts     (counts)
	);

	merge_sorter merge_sorter_inst (
		.clk        (clk),
		.reset      (reset),
		.phase      (phase),
		.counts     (counts),
		.merge      (merge),
		.sort_done  (sort_done)
	);

	code_builder code_builder_inst (
		.clk        (clk),
		.reset      (reset),
		.phase      (phase),
		.merge      (merge),
		.code       (code),
		.code_valid (code_valid)
	);

endmodule

/* huffman_chk.sv */
`timescale 1ns/1ns

module huffman_chk (
	input logic clk,
	input logic reset,
	input logic cnt_valid,
	input logic code_valid
);

	int assert_errors = 0;                              // failures so far

	// ==================================================
	// output control properties
	// ==================================================
	cnt_single_pulse: assert property (@(posedge clk) disable iff (reset)
		cnt_valid |=> !cnt_valid)
		else begin
			assert_errors++;
			$error("cnt_valid high for two cycles in a row");
		end

	code_valid_held: assert property (@(posedge clk)
		(!reset && code_valid) |=> code_valid)
		else begin
			assert_errors++;
			$error("code_valid fell while reset was low");
		end

	quiet_after_reset: assert property (@(posedge clk)
		reset |=> (!cnt_valid && !code_valid))
		else begin
			assert_errors++;
			$error("cnt_valid or code_valid high in the cycle after reset");
		end

endmodule

bind huffman huffman_chk huffman_chk_inst (
	.clk        (clk),
	.reset      (reset),
	.cnt_valid  (cnt_valid),
	.code_valid (code_valid)
);

/* huffman_pkg.sv */
package huffman_pkg;

	// ==================================================
	// sizes
	// ==================================================
	localparam int NUM_SYMBOLS = 6;
	localparam int COUNT_W     = 8;
	localparam int CODE_W      = 8;
	localparam int DATA_W      = 8;                     // gray_data width
	localparam int IDX_W       = $clog2(NUM_SYMBOLS);   // slot index width

	localparam logic [DATA_W-1:0] SYM_FIRST = 8'd1;     // value of symbol 1

	// ==================================================
	// shared types
	// ==================================================
	typedef logic [NUM_SYMBOLS-1:0] sym_mask_t;         // bit k is symbol k+1
	typedef logic [COUNT_W-1:0] count_t;
	typedef count_t [NUM_SYMBOLS-1:0] count_bank_t;

	typedef struct packed {
		count_t    count;
		sym_mask_t members;                             // symbols under this node
	} tree_entry_t;

	typedef struct packed {
		logic      strobe;
		sym_mask_t one_mask;                            // smallest entry, gets bit 1
		sym_mask_t zero_mask;                           // second smallest, gets bit 0
	} merge_event_t;

	typedef struct packed {
		logic [CODE_W-1:0] code;
		logic [CODE_W-1:0] mask;
	} code_word_t;

	typedef code_word_t [NUM_SYMBOLS-1:0] code_bank_t;

	typedef enum logic [2:0] {
		phase_idle,
		phase_receive,
		phase_count_out,
		phase_merge,
		phase_done
	} phase_t;

endpackage

/* huffman_sequencer.sv */
`timescale 1ns/1ns

module huffman_sequencer import huffman_pkg::*; (
	input  logic   clk,
	input  logic   reset,
	input  logic   gray_valid,
	input  logic   sort_done,
	output phase_t phase,
	output logic   cnt_valid
);

	phase_t phase_next;

	// ==================================================
	// phase transitions
	// ==================================================
	always_comb begin
		phase_next = phase;
		case (phase)
			phase_idle: begin
				if (gray_valid) begin
					phase_next = phase_receive;            // first sample seen
				end
			end
			phase_receive: begin
				if (!gray_valid) begin
					phase_next = phase_count_out;          // stream ended
				end
			end
			phase_count_out: begin
				phase_next = phase_merge;                 // single cycle
			end
			phase_merge: begin
				if (sort_done) begin
					phase_next = phase_done;
				end
			end
			phase_done: begin
				phase_next = phase_done;                  // held until reset
			end
			default: begin
				phase_next = phase_idle;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			phase <= phase_idle;
		end else begin
			phase <= phase_next;
		end
	end

	assign cnt_valid = (phase == phase_count_out);      // one cycle pulse

endmodule

/* merge_sorter.sv */
`timescale 1ns/1ns

module merge_sorter import huffman_pkg::*; (
	input  logic         clk,
	input  logic         reset,
	input  phase_t       phase,
	input  count_bank_t  counts,
	output merge_event_t merge,
	output logic         sort_done
);

	tree_entry_t [NUM_SYMBOLS-1:0] entry;               // live tree nodes

	logic             s_found;
	logic             t_found;
	logic [IDX_W-1:0] s_idx;                            // smallest slot
	logic [IDX_W-1:0] t_idx;                            // second smallest slot
	logic             do_merge;
	tree_entry_t      merged;

	// lower count wins, equal counts go to the lower member mask
	function automatic logic is_smaller(tree_entry_t a, tree_entry_t b);
		return (a.count < b.count) || (a.count == b.count && a.members < b.members);
	endfunction

	// ==================================================
	// smallest pair search
	// ==================================================
	always_comb begin
		s_found = 1'b0;
		t_found = 1'b0;
		s_idx   = '0;
		t_idx   = '0;
		for (int k = 0; k < NUM_SYMBOLS; k++) begin
			if (entry[k].count != '0) begin                // empty slots never take part
				if (!s_found || is_smaller(entry[k], entry[s_idx])) begin
					t_found = s_found;                       // old smallest moves down
					t_idx   = s_idx;
					s_found = 1'b1;
					s_idx   = IDX_W'(k);
				end else if (!t_found || is_smaller(entry[k], entry[t_idx])) begin
					t_found = 1'b1;
					t_idx   = IDX_W'(k);
				end
			end
		end
	end

	assign do_merge  = (phase == phase_merge) && t_found;
	assign sort_done = (phase == phase_merge) && !t_found;   // one node left

	always_comb begin
		merged.count   = entry[s_idx].count + entry[t_idx].count;
		merged.members = entry[s_idx].members | entry[t_idx].members;
	end

	always_comb begin
		merge.strobe    = do_merge;
		merge.one_mask  = do_merge ? entry[s_idx].members : '0;
		merge.zero_mask = do_merge ? entry[t_idx].members : '0;
	end

	// ==================================================
	// entry storage
	// ==================================================
	always_ff @(posedge clk) begin
		if (reset) begin
			entry <= '0;
		end else if (phase == phase_count_out) begin
			for (int k = 0; k < NUM_SYMBOLS; k++) begin
				entry[k].count   <= counts[k];
				entry[k].members <= (counts[k] != '0) ? sym_mask_t'(1 << k) : '0;
			end
		end else if (do_merge) begin
			entry[s_idx] <= merged;                      // parent takes the smaller slot
			entry[t_idx] <= '0;
		end
	end

endmodule

/* symbol_histogram.sv */
`timescale 1ns/1ns

module symbol_histogram import huffman_pkg::*; (
	input  logic              clk,
	input  logic              reset,
	input  phase_t            phase,
	input  logic              gray_valid,
	input  logic [DATA_W-1:0] gray_data,
	output count_bank_t       counts
);

	logic      take;                                    // sample accepted this cycle
	sym_mask_t hit;                                     // decoded symbol

	assign take = gray_valid && (phase == phase_idle || phase == phase_receive);

	// ==================================================
	// symbol decode
	// ==================================================
	always_comb begin
		for (int k = 0; k < NUM_SYMBOLS; k++) begin
			hit[k] = take && (gray_data == SYM_FIRST + DATA_W'(k));
		end
	end

	// out of range values hit nothing
	always_ff @(posedge clk) begin
		if (reset) begin
			counts <= '0;
		end else begin
			for (int k = 0; k < NUM_SYMBOLS; k++) begin
				if (hit[k]) begin
					counts[k] <= counts[k] + 1'b1;
				end
			end
		end
	end

endmodule

/* tb_huffman.sv */
`timescale 1ns/1ns

module tb_huffman import huffman_pkg::*; ();

	localparam int NUM_ROWS     = 4;
	localparam int CLK_HALF     = 50;
	localparam int RESET_CYCLES = 8;
	localparam int HOLD_CYCLES  = 20;
	localparam int CODE_WAIT    = 10;                   // cycles from cnt_valid to code_valid
	localparam int WATCHDOG_NS  = NUM_ROWS * (RESET_CYCLES + 300 + HOLD_CYCLES) * 100;

	typedef struct packed {
		count_bank_t counts;
		logic [7:0]  filler;                            // out of range values mixed in
		code_bank_t  codes;
	} row_t;

	logic              clk;
	logic              reset;
	logic              gray_valid;
	logic [DATA_W-1:0] gray_data;
	logic              cnt_valid;
	count_bank_t       counts;
	logic              code_valid;
	code_bank_t        code;

	row_t   table_rows [NUM_ROWS];
	integer seed;
	int     value_errors;
	int     timing_errors;
	int     cnt_pulses;                                 // cnt_valid cycles seen this row

	huffman huffman_inst (
		.clk        (clk),
		.reset      (reset),
		.gray_valid (gray_valid),
		.gray_data  (gray_data),
		.cnt_valid  (cnt_valid),
		.counts     (counts),
		.code_valid (code_valid),
		.code       (code)
	);

	initial begin
		clk = 1'b0;
		forever #CLK_HALF clk = ~clk;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the run took longer than its time limit");
		$display("Checks failed");
		$finish;
	end

	always @(negedge clk) begin
		if (!reset && cnt_valid) begin
			cnt_pulses++;
		end
	end

	// ==================================================
	// table helpers
	// ==================================================
	function automatic count_bank_t counts_of(input count_t c1, input count_t c2,
			input count_t c3, input count_t c4, input count_t c5, input count_t c6);
		count_bank_t b;
		b[0] = c1;                                      // symbol 1 sits at index 0
		b[1] = c2;
		b[2] = c3;
		b[3] = c4;
		b[4] = c5;
		b[5] = c6;
		return b;
	endfunction

	function automatic code_word_t code_entry(input logic [7:0] value, input logic [7:0] mask);
		code_word_t w;
		w.code = value;
		w.mask = mask;
		return w;
	endfunction

	function automatic code_bank_t codes_of(input code_word_t w1, input code_word_t w2,
			input code_word_t w3, input code_word_t w4, input code_word_t w5,
			input code_word_t w6);
		code_bank_t b;
		b[0] = w1;
		b[1] = w2;
		b[2] = w3;
		b[3] = w4;
		b[4] = w5;
		b[5] = w6;
		return b;
	endfunction

	// codes worked out by hand, smaller entry gets 1, ties go to the lower mask
	task automatic fill_table();
		table_rows[0].counts = counts_of(8'd20, 8'd10, 8'd5, 8'd3, 8'd2, 8'd1);  // skewed
		table_rows[0].filler = 8'd3;
		table_rows[0].codes  = codes_of(code_entry(8'h01, 8'h01), code_entry(8'h01, 8'h03),
			code_entry(8'h01, 8'h07), code_entry(8'h01, 8'h0f),
			code_entry(8'h00, 8'h1f), code_entry(8'h01, 8'h1f));
		table_rows[1].counts = counts_of(8'd4, 8'd4, 8'd4, 8'd4, 8'd4, 8'd4);    // all equal
		table_rows[1].filler = 8'd0;
		table_rows[1].codes  = codes_of(code_entry(8'h03, 8'h07), code_entry(8'h02, 8'h07),
			code_entry(8'h01, 8'h07), code_entry(8'h00, 8'h07),
			code_entry(8'h03, 8'h03), code_entry(8'h02, 8'h03));
		table_rows[2].counts = counts_of(8'd0, 8'd7, 8'd0, 8'd3, 8'd9, 8'd5);    // two absent
		table_rows[2].filler = 8'd5;
		table_rows[2].codes  = codes_of(code_entry(8'h00, 8'h00), code_entry(8'h01, 8'h03),
			code_entry(8'h00, 8'h00), code_entry(8'h01, 8'h07),
			code_entry(8'h01, 8'h01), code_entry(8'h00, 8'h07));
		table_rows[3].counts = counts_of(8'd0, 8'd0, 8'd1, 8'd0, 8'd0, 8'd1);    // one merge
		table_rows[3].filler = 8'd2;
		table_rows[3].codes  = codes_of(code_entry(8'h00, 8'h00), code_entry(8'h00, 8'h00),
			code_entry(8'h01, 8'h01), code_entry(8'h00, 8'h00),
			code_entry(8'h00, 8'h00), code_entry(8'h00, 8'h01));
	endtask

	task automatic compare(input string name, input logic [95:0] got,
			input logic [95:0] expected);
		if (got !== expected) begin
			$display("Fail %s got %0h expected %0h", name, got, expected);
			value_errors++;
		end
	endtask

	// ==================================================
	// stimulus
	// ==================================================
	task automatic apply_reset();
		@(negedge clk);
		reset      = 1'b1;
		gray_valid = 1'b0;
		gray_data  = '0;
		cnt_pulses = 0;
		repeat (RESET_CYCLES) @(negedge clk);
		compare("cnt_valid", 96'(cnt_valid), 96'(0));
		compare("code_valid", 96'(code_valid), 96'(0));
		compare("counts", 96'(counts), 96'(0));
		compare("code", 96'(code), 96'(0));
		reset = 1'b0;
	endtask

	task automatic send_stream(input row_t row);
		logic [DATA_W-1:0] stream [$];
		logic [DATA_W-1:0] filler_value;
		logic [DATA_W-1:0] held;
		int                j;
		for (int k = 0; k < NUM_SYMBOLS; k++) begin
			repeat (row.counts[k]) stream.push_back(DATA_W'(k + 1));
		end
		repeat (row.filler) begin
			filler_value = DATA_W'($random(seed));
			if (filler_value >= 8'd1 && filler_value <= 8'd6) begin
				filler_value = 8'd0;                        // keep it out of range
			end
			stream.push_back(filler_value);
		end
		for (int i = stream.size() - 1; i > 0; i--) begin
			j         = int'($unsigned($random(seed)) % (i + 1));
			held      = stream[i];
			stream[i] = stream[j];
			stream[j] = held;
		end
		foreach (stream[i]) begin
			gray_valid = 1'b1;
			gray_data  = stream[i];
			@(negedge clk);
		end
		gray_valid = 1'b0;
		gray_data  = '0;
	endtask

	// new data while done must not touch counts or codes
	task automatic hold_codes(input row_t row);
		for (int i = 0; i < HOLD_CYCLES; i++) begin
			gray_valid = ~gray_valid;
			gray_data  = DATA_W'($unsigned($random(seed)) % 6 + 1);
			@(negedge clk);
			compare("code_valid", 96'(code_valid), 96'(1));
			compare("code", 96'(code), 96'(row.codes));
			compare("counts", 96'(counts), 96'(row.counts));
		end
		gray_valid = 1'b0;
		gray_data  = '0;
	endtask

	// ==================================================
	// main sequence
	// ==================================================
	initial begin
		row_t row;
		int   present;
		int   latency;
		int   assert_errors;
		seed          = 32'h924f_12b4;
		value_errors  = 0;
		timing_errors = 0;
		cnt_pulses    = 0;
		reset         = 1'b1;
		gray_valid    = 1'b0;
		gray_data     = '0;
		fill_table();
		for (int r = 0; r < NUM_ROWS; r++) begin
			row     = table_rows[r];
			present = 0;
			for (int k = 0; k < NUM_SYMBOLS; k++) begin
				if (row.counts[k] != '0) begin
					present++;
				end
			end
			apply_reset();
			send_stream(row);
			@(negedge clk);                               // one cycle after gray_valid fell
			compare("cnt_valid", 96'(cnt_valid), 96'(1));
			for (int k = 0; k < NUM_SYMBOLS; k++) begin
				compare($sformatf("counts[%0d]", k), 96'(counts[k]), 96'(row.counts[k]));
			end
			latency = 0;
			for (int i = 1; i <= CODE_WAIT && latency == 0; i++) begin
				@(negedge clk);
				if (code_valid) begin
					latency = i;
				end
			end
			if (latency == 0) begin
				$display("code_valid did not rise within %0d cycles of cnt_valid in row %0d",
					CODE_WAIT, r);
				timing_errors++;
			end else begin
				// one merge per cycle, then the done cycle
				compare("code_valid latency", 96'(latency), 96'(present + 1));
				for (int k = 0; k < NUM_SYMBOLS; k++) begin
					compare($sformatf("code[%0d].code", k), 96'(code[k].code),
						96'(row.codes[k].code));
					compare($sformatf("code[%0d].mask", k), 96'(code[k].mask),
						96'(row.codes[k].mask));
				end
				hold_codes(row);
			end
			compare("cnt_valid pulses", 96'(cnt_pulses), 96'(1));
		end
		assert_errors = huffman_inst.huffman_chk_inst.assert_errors;
		$display("errors: %0d value, %0d timing, %0d assertion",
			value_errors, timing_errors, assert_errors);
		if (value_errors == 0 && timing_errors == 0 && assert_errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule
